/* Bender.yml */
package:
  name: vector_array

export_include_dirs:
  - verilog

sources:
  - verilog/array_pkg.sv
  - verilog/lane_fifo.sv
  - verilog/stream_feeder.sv
  - verilog/vector_column.sv
  - verilog/drain_control.sv
  - verilog/stream_collector.sv
  - verilog/vector_array_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/vector_array_props.sv
      - sim/vector_array_tb.sv

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;    // 8 ns period
    end

    // reset held over the first three rising edges
    initial begin
        o_rst = 1'b1;
        repeat (3) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

/* sim/vector_array_props.sv */
`timescale 1ns/1ps
`include "array_cfg.svh"

module vector_array_props (
    input logic                                     clk,
    input logic                                     rst,
    input logic                                     i_out_tvalid,
    input logic [`ARRAY_NUM_LANE*`ARRAY_LANE_W-1:0] i_out_tdata,
    input logic                                     i_out_tready,
    input logic                                     i_in_tready,
    input logic                                     i_drain_pending
);

    int unsigned prop_fails = 0;    // read by the testbench at the end

    // output fifos come out of reset empty
    a_idle_after_rst: assert property (@(posedge clk) rst |=> !i_out_tvalid)
        else begin
            prop_fails++;
            $error("o_out_tvalid high in the cycle after reset");
        end

    a_hold_data: assert property (@(posedge clk) disable iff (rst)
        (i_out_tvalid && !i_out_tready) |=> $stable(i_out_tdata))
        else begin
            prop_fails++;
            $error("o_out_tdata changed while the output was stalled");
        end

    // no new stream beats while a drain owns the chain
    a_no_input_in_drain: assert property (@(posedge clk) disable iff (rst)
        i_drain_pending |-> !i_in_tready)
        else begin
            prop_fails++;
            $error("o_in_tready high while a drain is pending");
        end

endmodule

bind vector_array_top vector_array_props u_props (
    .clk             (clk),
    .rst             (rst),
    .i_out_tvalid    (o_out_tvalid),
    .i_out_tdata     (o_out_tdata),
    .i_out_tready    (i_out_tready),
    .i_in_tready     (o_in_tready),
    .i_drain_pending (drain_pending)
);

/* sim/vector_array_tb.sv */
`timescale 1ns/1ps
`include "array_cfg.svh"

module vector_array_tb;
    import array_pkg::*;

    localparam int NC    = `ARRAY_NUM_COL;
    localparam int NL    = `ARRAY_NUM_LANE;
    localparam int W     = `ARRAY_LANE_W;
    localparam int DEPTH = `ARRAY_VRF_DEPTH;
    localparam int DW    = NL * W;
    localparam int MAX_CYCLES = 20000;    // five tests of up to 3x16 entries plus waits times a margin

    logic          clk;
    logic          rst;
    logic [DW-1:0] i_in_tdata;
    logic [NL*4-1:0] i_in_tkeep;
    logic          i_in_tvalid;
    logic          i_in_tlast;
    logic          o_in_tready;
    logic [DW-1:0] o_out_tdata;
    logic [NL*4-1:0] o_out_tkeep;
    logic          o_out_tvalid;
    logic          o_out_tlast;
    logic          i_out_tready;
    logic          i_cmd_valid;
    cmd_u          i_cmd;
    logic [NC-1:0] i_cmd_col;
    logic          o_busy;

    lane_word_t    model_vrf [NC][DEPTH][NL];
    logic [DW-1:0] exp_data [$];
    logic          exp_last [$];
    logic [DW-1:0] got_data [$];
    logic [NL*4-1:0] got_keep [$];
    logic          got_last [$];
    bit            toggle_ready;
    int            cycles;
    int            err_count;
    int            check_count;
    int            test_num;
    int            test_errs;

    tb_clock u_clock (.o_clk(clk), .o_rst(rst));

    vector_array_top dut (.*);

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped at cycle %0d, the DUT never finished the tests", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // output sink with random back-pressure when asked for
    always @(posedge clk) begin
        if (!rst && o_out_tvalid && i_out_tready) begin
            got_data.push_back(o_out_tdata);
            got_keep.push_back(o_out_tkeep);
            got_last.push_back(o_out_tlast);
        end
        i_out_tready <= toggle_ready ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    task automatic check_value(input string name, input logic [DW-1:0] expected,
                               input logic [DW-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic issue_cmd(input cmd_u c, input logic [NC-1:0] cols);
        @(posedge clk);
        i_cmd_valid <= 1'b1;
        i_cmd       <= c;
        i_cmd_col   <= cols;
        @(posedge clk);
        i_cmd_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        do @(posedge clk); while (o_busy);
    endtask

    // each lane full, empty or a partial nibble with at least one full lane kept
    function automatic logic [NL*4-1:0] random_keep();
        logic [NL*4-1:0] keep;
        int r;
        for (int l = 0; l < NL; l++) begin
            r = $urandom_range(0, 2);
            keep[l*4 +: 4] = (r == 0) ? 4'hf : (r == 1) ? 4'h0 : 4'($urandom_range(1, 14));
        end
        r = 0;
        for (int l = 0; l < NL; l++)
            r += (keep[l*4 +: 4] == 4'hf);
        if (r == 0)
            keep[$urandom_range(0, NL - 1)*4 +: 4] = 4'hf;
        return keep;
    endfunction

    task automatic run_macc(input bit partial);
        cmd_u c;
        int vd;
        int vs;
        int len;
        int wa;
        int ra;
        logic [DW-1:0] data;
        logic [NL*4-1:0] keep;
        vd  = $urandom_range(0, DEPTH - 1);
        vs  = $urandom_range(0, DEPTH - 1);
        len = $urandom_range(1, DEPTH);
        c = '0;
        c.macc.op  = OP_MACC;
        c.macc.vd  = ADDR_W'(vd);
        c.macc.vs  = ADDR_W'(vs);
        c.macc.len = LEN_W'(len);
        issue_cmd(c, '1);
        for (int b = 0; b < len; b++) begin
            for (int l = 0; l < NL; l++)
                data[l*W +: W] = $urandom;
            keep = partial ? random_keep() : '1;
            wa = (vd + b) % DEPTH;
            ra = (vs + b) % DEPTH;
            for (int col = 0; col < NC; col++) begin
                for (int l = 0; l < NL; l++) begin
                    if (keep[l*4 +: 4] == 4'hf)
                        model_vrf[col][wa][l] = model_vrf[col][wa][l]
                                                + data[l*W +: W] * model_vrf[col][ra][l];
                end
            end
            i_in_tvalid <= 1'b1;
            i_in_tdata  <= data;
            i_in_tkeep  <= keep;
            i_in_tlast  <= (b == len - 1);
            do @(posedge clk); while (!o_in_tready);
        end
        i_in_tvalid <= 1'b0;
        wait_idle();
    endtask

    task automatic run_drain(input logic [NC-1:0] cols, input int vd, input int len);
        cmd_u c;
        logic [DW-1:0] entry;
        int last_col;
        for (int col = 0; col < NC; col++)
            if (cols[col])
                last_col = col;
        exp_data.delete();
        exp_last.delete();
        for (int col = 0; col < NC; col++) begin
            for (int k = 0; k < len && cols[col]; k++) begin
                for (int l = 0; l < NL; l++)
                    entry[l*W +: W] = model_vrf[col][(vd + k) % DEPTH][l];
                exp_data.push_back(entry);
                exp_last.push_back(col == last_col && k == len - 1);
            end
        end
        got_data.delete();
        got_keep.delete();
        got_last.delete();
        c = '0;
        c.move.op  = OP_DRAIN;
        c.move.vd  = ADDR_W'(vd);
        c.move.len = LEN_W'(len);
        issue_cmd(c, cols);
        wait_idle();
        check_value("output beat count", exp_data.size(), got_data.size());
        for (int i = 0; i < exp_data.size() && i < got_data.size(); i++) begin
            check_value($sformatf("o_out_tdata[%0d]", i), exp_data[i], got_data[i]);
            check_value($sformatf("o_out_tkeep[%0d]", i), {NL*4{1'b1}}, got_keep[i]);
            check_value($sformatf("o_out_tlast[%0d]", i), exp_last[i], got_last[i]);
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %s", test_num, name, (err_count == test_errs) ? "ok" : "FAILED");
        test_errs = err_count;
    endtask

    initial begin
        cmd_u c;
        int len;
        int total;
        void'($urandom(28));
        i_in_tdata   = '0;
        i_in_tkeep   = '0;
        i_in_tvalid  = 1'b0;
        i_in_tlast   = 1'b0;
        i_out_tready = 1'b1;
        i_cmd_valid  = 1'b0;
        i_cmd        = '0;
        i_cmd_col    = '0;
        do @(posedge clk); while (rst);

        c = '0;
        c.move.op  = OP_CLEAR;
        c.move.len = LEN_W'(DEPTH);
        issue_cmd(c, '1);
        wait_idle();
        for (int col = 0; col < NC; col++)
            for (int e = 0; e < DEPTH; e++)
                for (int l = 0; l < NL; l++)
                    model_vrf[col][e][l] = '0;
        run_drain('1, 0, DEPTH);
        end_test("clear then drain all columns");

        run_macc(1'b0);
        run_drain('1, 0, DEPTH);
        end_test("random macc, full keep");

        run_macc(1'b1);
        run_drain('1, 0, DEPTH);
        end_test("random macc, partial keep");

        toggle_ready = 1'b1;
        run_macc(1'b0);
        run_drain('1, 0, DEPTH);
        toggle_ready = 1'b0;
        end_test("macc and drain under back-pressure");

        len = $urandom_range(1, DEPTH);
        run_drain(3'b101, $urandom_range(0, DEPTH - 1), len);
        run_drain(3'b010, $urandom_range(0, DEPTH - 1), (len % DEPTH) + 1);
        @(posedge clk);
        check_value("o_in_tready", 1'b1, o_in_tready);
        end_test("sparse column masks");

        total = err_count + dut.u_props.prop_fails;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_num, check_count, err_count, dut.u_props.prop_fails);
        if (total == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* src.f */
+incdir+verilog
verilog/array_pkg.sv
verilog/lane_fifo.sv
verilog/stream_feeder.sv
verilog/vector_column.sv
verilog/drain_control.sv
verilog/stream_collector.sv
verilog/vector_array_top.sv
sim/tb_clock.sv
sim/vector_array_props.sv
sim/vector_array_tb.sv

/* verilog/array_cfg.svh */
`ifndef ARRAY_CFG_SVH
`define ARRAY_CFG_SVH

// array geometry
`define ARRAY_NUM_COL    3
`define ARRAY_NUM_LANE   4
`define ARRAY_LANE_W     32    // integer lanes

// storage sizes
`define ARRAY_VRF_DEPTH  16    // vector entries per column
`define ARRAY_FIFO_DEPTH 16    // words per lane fifo

`endif

/* verilog/array_pkg.sv */
`include "array_cfg.svh"

package array_pkg;

    localparam int ADDR_W = $clog2(`ARRAY_VRF_DEPTH);
    localparam int LEN_W  = $clog2(`ARRAY_VRF_DEPTH) + 1;   // lengths run 1..depth

    typedef logic [`ARRAY_LANE_W-1:0] lane_word_t;

    // one chain beat, all lanes side by side
    typedef struct packed {
        lane_word_t [`ARRAY_NUM_LANE-1:0] data;
        logic [`ARRAY_NUM_LANE-1:0]       valid;
        logic                             last;
    } beat_t;

    // one word of a lane fifo
    typedef struct packed {
        lane_word_t data;
        logic       valid;
        logic       last;
    } lane_ent_t;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_CLEAR = 2'd1,
        OP_MACC  = 2'd2,
        OP_DRAIN = 2'd3
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e           op;
        logic [ADDR_W-1:0] vd;     // accumulate into
        logic [ADDR_W-1:0] vs;     // multiply by
        logic [LEN_W-1:0]  len;    // in beats
        logic              rsvd;
    } cmd_macc_t;

    // clear and drain only need a start and a run length
    typedef struct packed {
        cmd_op_e           op;
        logic [ADDR_W-1:0] vd;
        logic [LEN_W-1:0]  len;    // in entries
        logic [ADDR_W:0]   spare;
    } cmd_move_t;

    typedef union packed {
        cmd_macc_t macc;
        cmd_move_t move;
    } cmd_u;

endpackage

/* verilog/drain_control.sv */
`timescale 1ns/1ps
`include "array_cfg.svh"

module drain_control (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_cmd_valid,
    input  array_pkg::cmd_u           i_cmd,
    input  logic [`ARRAY_NUM_COL-1:0] i_cmd_col,
    input  logic [`ARRAY_NUM_COL-1:0] i_drain_done,
    output logic [`ARRAY_NUM_COL-1:0] o_supplier,
    output logic                      o_last_supplier,
    output logic                      o_drain_pending
);
    import array_pkg::*;

    logic [`ARRAY_NUM_COL-1:0] pend_q;     // columns still to drain

    always_ff @(posedge clk) begin
        if (rst)
            pend_q <= '0;
        else if (i_cmd_valid && (i_cmd.move.op == OP_DRAIN))
            pend_q <= i_cmd_col;
        else
            pend_q <= pend_q & ~i_drain_done;
    end

    // isolate lowest set bit, so columns supply in ascending order
    assign o_supplier = pend_q & (~pend_q + 1'b1);

    assign o_last_supplier = (pend_q != '0) && ((pend_q & ~o_supplier) == '0);
    assign o_drain_pending = |pend_q;

endmodule

/* verilog/lane_fifo.sv */
`timescale 1ns/1ps
`include "array_cfg.svh"

module lane_fifo #(
    parameter int DEPTH = `ARRAY_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_push,
    input  logic                 i_pop,
    input  array_pkg::lane_ent_t i_data,
    output array_pkg::lane_ent_t o_data,
    output logic                 o_empty,
    output logic                 o_full
);
    import array_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    lane_ent_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push && !o_full;    // dropped when full
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= i_data;
    end

    // show-ahead read
    assign o_data  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == (PTR_W + 1)'(DEPTH));

endmodule

/* verilog/stream_collector.sv */
`timescale 1ns/1ps
`include "array_cfg.svh"

module stream_collector (
    input  logic                                      clk,
    input  logic                                      rst,
    input  array_pkg::beat_t                          i_beat,
    input  logic                                      i_tready,
    output logic [`ARRAY_NUM_LANE*`ARRAY_LANE_W-1:0] o_tdata,
    output logic [`ARRAY_NUM_LANE*4-1:0]             o_tkeep,
    output logic                                      o_tvalid,
    output logic                                      o_tlast,
    output logic                                      o_stall,
    output logic                                      o_empty
);
    import array_pkg::*;

    localparam int NL = `ARRAY_NUM_LANE;
    localparam int W  = `ARRAY_LANE_W;

    lane_ent_t     push_ent [NL];
    lane_ent_t     pop_ent  [NL];
    logic [NL-1:0] lane_full;
    logic [NL-1:0] lane_empty;
    logic [NL-1:0] lane_last;
    logic          push;
    logic          pop;

    assign o_stall  = |lane_full;     // holds the whole chain
    assign push     = (|i_beat.valid) && !o_stall;
    assign o_empty  = &lane_empty;
    assign o_tvalid = !(|lane_empty);
    assign pop      = o_tvalid && i_tready;
    assign o_tlast  = o_tvalid && (&lane_last);

    always_comb begin
        for (int l = 0; l < NL; l++) begin
            push_ent[l] = '{data: i_beat.data[l], valid: i_beat.valid[l], last: i_beat.last};
            o_tdata[l*W +: W]  = pop_ent[l].data;
            o_tkeep[l*4 +: 4]  = {4{pop_ent[l].valid}};   // lane valid back to a keep nibble
            lane_last[l]       = pop_ent[l].last;
        end
    end

    for (genvar l = 0; l < NL; l++) begin : g_lane
        lane_fifo u_fifo (
            .clk     (clk),
            .rst     (rst),
            .i_push  (push),
            .i_pop   (pop),
            .i_data  (push_ent[l]),
            .o_data  (pop_ent[l]),
            .o_empty (lane_empty[l]),
            .o_full  (lane_full[l])
        );
    end

endmodule

/* verilog/stream_feeder.sv */
`timescale 1ns/1ps
`include "array_cfg.svh"

module stream_feeder (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [`ARRAY_NUM_LANE*`ARRAY_LANE_W-1:0] i_tdata,
    input  logic [`ARRAY_NUM_LANE*4-1:0]             i_tkeep,
    input  logic                                      i_tvalid,
    input  logic                                      i_tlast,
    output logic                                      o_tready,
    input  logic                                      i_macc_active,
    input  logic                                      i_drain_pending,
    input  logic                                      i_stall,
    output array_pkg::beat_t                          o_head_beat
);
    import array_pkg::*;

    localparam int NL = `ARRAY_NUM_LANE;
    localparam int W  = `ARRAY_LANE_W;

    lane_ent_t     push_ent [NL];
    lane_ent_t     pop_ent  [NL];
    logic [NL-1:0] lane_full;
    logic [NL-1:0] lane_empty;
    logic          push;
    logic          pop;

    assign o_tready = !(|lane_full) && !i_drain_pending;
    assign push     = i_tvalid && o_tready;
    // every beat lands in all lanes, so the fifos fill and empty together
    assign pop = i_macc_active && !i_stall && !i_drain_pending && !(|lane_empty);

    always_comb begin
        for (int l = 0; l < NL; l++) begin
            push_ent[l] = '{data:  i_tdata[l*W +: W],
                            valid: &i_tkeep[l*4 +: 4],   // needs the whole nibble
                            last:  i_tlast};
        end
    end

    for (genvar l = 0; l < NL; l++) begin : g_lane
        lane_fifo u_fifo (
            .clk     (clk),
            .rst     (rst),
            .i_push  (push),
            .i_pop   (pop),
            .i_data  (push_ent[l]),
            .o_data  (pop_ent[l]),
            .o_empty (lane_empty[l]),
            .o_full  (lane_full[l])
        );
    end

    // head of the chain, empty beat when nothing popped
    always_ff @(posedge clk) begin
        if (rst) begin
            o_head_beat.valid <= '0;
            o_head_beat.last  <= 1'b0;
        end else if (!i_stall) begin
            for (int l = 0; l < NL; l++) begin
                o_head_beat.data[l]  <= pop_ent[l].data;
                o_head_beat.valid[l] <= pop && pop_ent[l].valid;
            end
            o_head_beat.last <= pop && pop_ent[0].last;
        end
    end

endmodule

/* verilog/vector_array_top.sv */
`timescale 1ns/1ps
`include "array_cfg.svh"

module vector_array_top (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [`ARRAY_NUM_LANE*`ARRAY_LANE_W-1:0] i_in_tdata,
    input  logic [`ARRAY_NUM_LANE*4-1:0]             i_in_tkeep,
    input  logic                                      i_in_tvalid,
    input  logic                                      i_in_tlast,
    output logic                                      o_in_tready,
    output logic [`ARRAY_NUM_LANE*`ARRAY_LANE_W-1:0] o_out_tdata,
    output logic [`ARRAY_NUM_LANE*4-1:0]             o_out_tkeep,
    output logic                                      o_out_tvalid,
    output logic                                      o_out_tlast,
    input  logic                                      i_out_tready,
    input  logic                                      i_cmd_valid,
    input  array_pkg::cmd_u                           i_cmd,
    input  logic [`ARRAY_NUM_COL-1:0]                 i_cmd_col,
    output logic                                      o_busy
);
    import array_pkg::*;

    localparam int NC = `ARRAY_NUM_COL;
    localparam int NL = `ARRAY_NUM_LANE;

    beat_t         chain_beat [NC+1];   // [0] is the head beat from the feeder
    beat_t         coll_beat;
    logic [NC-1:0] col_busy;
    logic [NC-1:0] macc_active;
    logic [NC-1:0] drain_done;
    logic [NC-1:0] supplier;
    logic [NC:0]   chain_valid;
    logic          last_supplier;
    logic          drain_pending;
    logic          stall;
    logic          out_empty;
    logic          cmd_take;
    logic          out_open;            // chain carries drained entries
    logic          all_idle;

    assign cmd_take = i_cmd_valid && !o_busy;

    stream_feeder u_feeder (
        .clk             (clk),
        .rst             (rst),
        .i_tdata         (i_in_tdata),
        .i_tkeep         (i_in_tkeep),
        .i_tvalid        (i_in_tvalid),
        .i_tlast         (i_in_tlast),
        .o_tready        (o_in_tready),
        .i_macc_active   (|macc_active),
        .i_drain_pending (drain_pending),
        .i_stall         (stall),
        .o_head_beat     (chain_beat[0])
    );

    for (genvar j = 0; j < NC; j++) begin : g_col
        vector_column u_col (
            .clk             (clk),
            .rst             (rst),
            .i_cmd_valid     (cmd_take),
            .i_cmd           (i_cmd),
            .i_sel           (i_cmd_col[j]),
            .i_prev_beat     (chain_beat[j]),
            .i_stall         (stall),
            .i_supplier      (supplier[j]),
            .i_last_supplier (last_supplier),
            .o_beat          (chain_beat[j+1]),
            .o_macc_active   (macc_active[j]),
            .o_busy          (col_busy[j]),
            .o_drain_done    (drain_done[j])
        );
    end

    drain_control u_drain (
        .clk             (clk),
        .rst             (rst),
        .i_cmd_valid     (cmd_take),
        .i_cmd           (i_cmd),
        .i_cmd_col       (i_cmd_col),
        .i_drain_done    (drain_done),
        .o_supplier      (supplier),
        .o_last_supplier (last_supplier),
        .o_drain_pending (drain_pending)
    );

    // stream beats leaving the last column after a MACC are dropped here
    always_comb begin
        coll_beat       = chain_beat[NC];
        coll_beat.valid = chain_beat[NC].valid & {NL{out_open}};
    end

    stream_collector u_coll (
        .clk      (clk),
        .rst      (rst),
        .i_beat   (coll_beat),
        .i_tready (i_out_tready),
        .o_tdata  (o_out_tdata),
        .o_tkeep  (o_out_tkeep),
        .o_tvalid (o_out_tvalid),
        .o_tlast  (o_out_tlast),
        .o_stall  (stall),
        .o_empty  (out_empty)
    );

    always_comb begin
        for (int k = 0; k <= NC; k++)
            chain_valid[k] = |chain_beat[k].valid;
    end

    assign all_idle = !(|col_busy) && !drain_pending && !(|chain_valid) && out_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_busy   <= 1'b0;
            out_open <= 1'b0;
        end else if (cmd_take) begin
            o_busy   <= 1'b1;
            out_open <= (i_cmd.move.op == OP_DRAIN);
        end else if (all_idle) begin
            o_busy <= 1'b0;
        end
    end

endmodule

/* verilog/vector_column.sv */
`timescale 1ns/1ps
`include "array_cfg.svh"

module vector_column (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_cmd_valid,
    input  array_pkg::cmd_u  i_cmd,
    input  logic             i_sel,
    input  array_pkg::beat_t i_prev_beat,
    input  logic             i_stall,
    input  logic             i_supplier,
    input  logic             i_last_supplier,
    output array_pkg::beat_t o_beat,
    output logic             o_macc_active,
    output logic             o_busy,
    output logic             o_drain_done
);
    import array_pkg::*;

    localparam int NL = `ARRAY_NUM_LANE;

    lane_word_t [NL-1:0] vrf [`ARRAY_VRF_DEPTH];

    cmd_op_e           op_q;
    logic              busy_q;
    logic [ADDR_W-1:0] vd_q;
    logic [ADDR_W-1:0] vs_q;
    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  cnt;        // entries done so far
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    logic              take;
    logic              clr_step;
    logic              macc_step;
    logic              drain_step;
    logic              step;
    logic              final_step;

    assign take = i_cmd_valid && i_sel && !busy_q && (i_cmd.macc.op != OP_NOP);

    // runs wrap around the register file
    assign wr_addr = vd_q + cnt[ADDR_W-1:0];
    assign rd_addr = vs_q + cnt[ADDR_W-1:0];

    assign clr_step   = busy_q && (op_q == OP_CLEAR) && !i_stall;
    assign macc_step  = busy_q && (op_q == OP_MACC) && !i_stall && (|i_prev_beat.valid);
    assign drain_step = busy_q && (op_q == OP_DRAIN) && !i_stall && i_supplier
                        && !(|i_prev_beat.valid);   // upstream entries pass first
    assign step       = clr_step || macc_step || drain_step;
    assign final_step = step && (cnt == len_q - 1'b1);

    assign o_macc_active = busy_q && (op_q == OP_MACC);
    assign o_busy        = busy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            op_q   <= OP_NOP;
            cnt    <= '0;
        end else if (take) begin
            busy_q <= 1'b1;
            op_q   <= i_cmd.macc.op;
            cnt    <= '0;
        end else if (final_step) begin
            busy_q <= 1'b0;
            cnt    <= '0;
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

    // vd sits at the same position in both views but the length does not
    always_ff @(posedge clk) begin
        if (take) begin
            vd_q  <= i_cmd.macc.vd;
            vs_q  <= i_cmd.macc.vs;
            len_q <= (i_cmd.macc.op == OP_MACC) ? i_cmd.macc.len : i_cmd.move.len;
        end
    end

    // read-modify-write in one cycle where untouched lanes keep their value
    always_ff @(posedge clk) begin
        if (clr_step) begin
            vrf[wr_addr] <= '0;
        end else if (macc_step) begin
            for (int l = 0; l < NL; l++) begin
                if (i_prev_beat.valid[l])
                    vrf[wr_addr][l] <= vrf[wr_addr][l] + i_prev_beat.data[l] * vrf[rd_addr][l];
            end
        end
    end

    // chain stage where the supplier puts its own entries in place of a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            o_beat.valid <= '0;
            o_beat.last  <= 1'b0;
        end else if (drain_step) begin
            o_beat.data  <= vrf[wr_addr];
            o_beat.valid <= '1;
            o_beat.last  <= i_last_supplier && final_step;
        end else if (!i_stall) begin
            o_beat <= i_prev_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            o_drain_done <= 1'b0;
        else
            o_drain_done <= drain_step && final_step;   // last entry now on the chain
    end

endmodule
